//--- list.f
+incdir+.
vcache_prof_pkg.sv
prof_counter_bank.sv
prof_op_counter.sv
prof_activity_counter.sv
prof_report_serializer.sv
vcache_profiler_top.sv
tb_vcache_profiler.sv

//--- run.sh
#!/bin/sh
# build and run the vcache profiler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_vcache_profiler \
  -f list.f \
  -o sim_vcache_profiler > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim_vcache_profiler > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb_vcache_profiler.sv
// vcache profiler testbench
`timescale 1ns/10ps
`default_nettype none

`include "vcache_prof_defines.svh"

module tb_vcache_profiler;

  localparam int stim_cycles_lp   = 2000;
  localparam int timeout_cycles_lp = 3000;   // stimulus plus reset and a final report

  logic                             clk_i;
  logic                             reset_i;
  logic                             v_i;
  logic                             yumi_i;
  logic                             miss_i;
  vcache_prof_pkg::cache_decode_s   decode_i;
  logic [`PROF_MASK_WIDTH-1:0]      mask_i;
  logic                             dma_v_i;
  logic                             dma_yumi_i;
  logic                             dma_write_i;
  logic [`PROF_CTR_WIDTH-1:0]       global_ctr_i;
  logic                             print_v_i;
  logic [`PROF_TAG_WIDTH-1:0]       print_tag_i;
  logic                             rpt_v_o;
  logic [$clog2(`PROF_RPT_WORDS)-1:0] rpt_idx_o;
  logic [`PROF_CTR_WIDTH-1:0]       rpt_data_o;
  logic                             busy_o;

  integer                     seed = 32'h0c3f46d1;
  int                         cycle_cnt = 0;
  logic [`PROF_CTR_WIDTH-1:0] op_m [0:`PROF_OP_FIELDS-1];   // reference counts
  logic [`PROF_CTR_WIDTH-1:0] act_m [0:`PROF_ACT_FIELDS-1];
  logic [`PROF_CTR_WIDTH-1:0] exp_words [0:`PROF_RPT_WORDS-1];
  logic [`PROF_CTR_WIDTH-1:0] exp_data;
  logic                       m_busy;
  logic [5:0]                 m_idx;
  int                         reports_started = 0;
  int                         reports_done = 0;
  int                         strobes_ignored = 0;

  vcache_profiler_top vcache_profiler_top_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .v_i          (v_i),
    .yumi_i       (yumi_i),
    .miss_i       (miss_i),
    .decode_i     (decode_i),
    .mask_i       (mask_i),
    .dma_v_i      (dma_v_i),
    .dma_yumi_i   (dma_yumi_i),
    .dma_write_i  (dma_write_i),
    .global_ctr_i (global_ctr_i),
    .print_v_i    (print_v_i),
    .print_tag_i  (print_tag_i),
    .rpt_v_o      (rpt_v_o),
    .rpt_idx_o    (rpt_idx_o),
    .rpt_data_o   (rpt_data_o),
    .busy_o       (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= timeout_cycles_lp);
    $display("timeout: run still going after %0d cycles", timeout_cycles_lp);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  task automatic report_error(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("** Error at %0t: %s got %h, expected %h", $time, what, got, exp);
    $display("STATUS: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  // one random cycle of cache, dma and print activity
  task automatic drive_random();
    logic [31:0]                    rnd;
    logic [31:0]                    rnd2;
    vcache_prof_pkg::cache_decode_s d;
    logic [7:0]                     m;
    rnd  = $random(seed);
    rnd2 = $random(seed);
    d    = '0;
    case (rnd[10:7])
      4'd0, 4'd1, 4'd2, 4'd3: d.ld_op = 1'b1;
      4'd4, 4'd5, 4'd6: d.st_op = 1'b1;
      4'd7: d.tagst_op = 1'b1;
      4'd8: d.tagfl_op = 1'b1;
      4'd9: d.taglv_op = 1'b1;
      4'd10: d.tagla_op = 1'b1;
      4'd11: d.afl_op = 1'b1;
      4'd12: d.aflinv_op = 1'b1;
      4'd13: d.ainv_op = 1'b1;
      4'd14: begin
        d.alock_op   = rnd[11];
        d.aunlock_op = ~rnd[11];
      end
      default: d.atomic_op = 1'b1;
    endcase
    d.mask_op      = rnd[12];
    d.data_size_op = rnd[14:13];
    d.sigext_op    = rnd[15];
    d.amo_subop    = vcache_prof_pkg::amo_subop_e'(rnd[17:16]);
    case (rnd[20:18])
      3'd0: m = 8'hff;
      3'd1: m = 8'h0f;
      3'd2: m = 8'hc0;
      3'd3: m = 8'h10;
      3'd4: m = 8'h3c;
      3'd5: m = 8'h07;   // popcount 3 hits no subclass
      3'd6: m = 8'h00;
      default: m = rnd[31:24];
    endcase
    v_i          <= rnd[0] | rnd[1];
    yumi_i       <= rnd[2] | rnd[3];
    miss_i       <= (rnd[5:4] == 2'd0);
    decode_i     <= d;
    mask_i       <= m;
    dma_v_i      <= rnd[21];
    dma_yumi_i   <= rnd[22];
    dma_write_i  <= rnd[23];
    print_v_i    <= (rnd2[4:0] == 5'd0);   // often lands inside a report
    print_tag_i  <= rnd2 ^ rnd;            // every tag bit varies at a strobe
    global_ctr_i <= global_ctr_i + 32'd1;
  endtask

  // reference model, reads inputs as sampled at this edge
  always @(posedge clk_i) begin
    logic acc;
    int   li;
    acc = v_i & yumi_i;
    if (reset_i) begin
      for (int i = 0; i < `PROF_OP_FIELDS; i++) op_m[i] = '0;
      for (int i = 0; i < `PROF_ACT_FIELDS; i++) act_m[i] = '0;
      m_busy = 1'b0;
      m_idx  = '0;
    end else begin
      if (m_busy) begin
        if (print_v_i) strobes_ignored++;
        if (m_idx == 6'd35) begin
          m_busy = 1'b0;
          m_idx  = '0;
          reports_done++;
        end else begin
          m_idx = m_idx + 6'd1;
        end
      end else if (print_v_i) begin
        exp_words[0] = global_ctr_i;
        exp_words[1] = print_tag_i;
        for (int i = 0; i < `PROF_OP_FIELDS; i++) exp_words[2 + i] = op_m[i];
        for (int i = 0; i < `PROF_ACT_FIELDS; i++) exp_words[28 + i] = act_m[i];
        m_busy = 1'b1;
        m_idx  = '0;
        reports_started++;
      end
      if (acc && decode_i.ld_op && !miss_i) begin
        op_m[0] = op_m[0] + 1;
        if (!decode_i.mask_op) begin
          li = 1 + 2 * (3 - int'(decode_i.data_size_op)) + (decode_i.sigext_op ? 0 : 1);
          op_m[li] = op_m[li] + 1;
        end
      end
      if (acc && decode_i.st_op && !miss_i) begin
        op_m[9] = op_m[9] + 1;
        if (decode_i.mask_op) begin
          case ($countones(mask_i))
            8: op_m[10] = op_m[10] + 1;
            4: op_m[11] = op_m[11] + 1;
            2: op_m[12] = op_m[12] + 1;
            1: op_m[13] = op_m[13] + 1;
            default: ;
          endcase
        end
      end
      if (acc) begin
        if (decode_i.tagst_op) op_m[14] = op_m[14] + 1;
        if (decode_i.tagfl_op) op_m[15] = op_m[15] + 1;
        if (decode_i.taglv_op) op_m[16] = op_m[16] + 1;
        if (decode_i.tagla_op) op_m[17] = op_m[17] + 1;
        if (decode_i.afl_op) op_m[18] = op_m[18] + 1;
        if (decode_i.aflinv_op) op_m[19] = op_m[19] + 1;
        if (decode_i.ainv_op) op_m[20] = op_m[20] + 1;
        if (decode_i.alock_op) op_m[21] = op_m[21] + 1;
        if (decode_i.aunlock_op) op_m[22] = op_m[22] + 1;
        if (decode_i.atomic_op) begin
          op_m[23] = op_m[23] + 1;
          if (decode_i.amo_subop == vcache_prof_pkg::e_amo_swap) op_m[24] = op_m[24] + 1;
          if (decode_i.amo_subop == vcache_prof_pkg::e_amo_or) op_m[25] = op_m[25] + 1;
        end
      end
      if (acc && miss_i && decode_i.ld_op) act_m[0] = act_m[0] + 1;
      if (acc && miss_i && decode_i.st_op) act_m[1] = act_m[1] + 1;
      if (acc && miss_i && decode_i.atomic_op) act_m[2] = act_m[2] + 1;
      if (miss_i) act_m[3] = act_m[3] + 1;
      if (v_i && !yumi_i) act_m[5] = act_m[5] + 1;
      else if (!acc && !miss_i) act_m[4] = act_m[4] + 1;
      if (dma_v_i && dma_yumi_i) begin
        if (dma_write_i) act_m[7] = act_m[7] + 1;
        else act_m[6] = act_m[6] + 1;
      end
    end
  end

  assign exp_data = exp_words[m_idx];

  a_reset_idle: assert property (@(posedge clk_i) $past(reset_i) |-> (!rpt_v_o && !busy_o))
    else report_error("outputs after reset", $sampled({rpt_v_o, busy_o}), 32'd0);

  a_frame_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    (rpt_v_o == m_busy) && (busy_o == m_busy))
    else report_error("rpt_v_o and busy_o", $sampled({rpt_v_o, busy_o}),
                      $sampled({m_busy, m_busy}));

  a_frame_idx: assert property (@(posedge clk_i) disable iff (reset_i)
    m_busy |-> (rpt_idx_o == m_idx))
    else report_error("report index", $sampled(rpt_idx_o), $sampled(m_idx));

  a_header: assert property (@(posedge clk_i) disable iff (reset_i)
    (m_busy && m_idx < 6'd2) |-> (rpt_data_o == exp_data))
    else report_error($sformatf("header word %0d", $sampled(m_idx)),
                      $sampled(rpt_data_o), $sampled(exp_data));

  a_load: assert property (@(posedge clk_i) disable iff (reset_i)
    (m_busy && m_idx >= 6'd2 && m_idx <= 6'd10) |-> (rpt_data_o == exp_data))
    else report_error($sformatf("load word %0d", $sampled(m_idx)),
                      $sampled(rpt_data_o), $sampled(exp_data));

  a_store: assert property (@(posedge clk_i) disable iff (reset_i)
    (m_busy && m_idx >= 6'd11 && m_idx <= 6'd15) |-> (rpt_data_o == exp_data))
    else report_error($sformatf("store word %0d", $sampled(m_idx)),
                      $sampled(rpt_data_o), $sampled(exp_data));

  a_tag_addr_amo: assert property (@(posedge clk_i) disable iff (reset_i)
    (m_busy && m_idx >= 6'd16 && m_idx <= 6'd27) |-> (rpt_data_o == exp_data))
    else report_error($sformatf("tag/address/atomic word %0d", $sampled(m_idx)),
                      $sampled(rpt_data_o), $sampled(exp_data));

  a_activity: assert property (@(posedge clk_i) disable iff (reset_i)
    (m_busy && m_idx >= 6'd28 && m_idx <= 6'd33) |-> (rpt_data_o == exp_data))
    else report_error($sformatf("activity word %0d", $sampled(m_idx)),
                      $sampled(rpt_data_o), $sampled(exp_data));

  a_dma: assert property (@(posedge clk_i) disable iff (reset_i)
    (m_busy && m_idx >= 6'd34) |-> (rpt_data_o == exp_data))
    else report_error($sformatf("dma word %0d", $sampled(m_idx)),
                      $sampled(rpt_data_o), $sampled(exp_data));

  initial begin
    reset_i      = 1'b1;
    v_i          = 1'b0;
    yumi_i       = 1'b0;
    miss_i       = 1'b0;
    decode_i     = '0;
    mask_i       = '0;
    dma_v_i      = 1'b0;
    dma_yumi_i   = 1'b0;
    dma_write_i  = 1'b0;
    global_ctr_i = 32'h1000_0000;
    print_v_i    = 1'b0;
    print_tag_i  = '0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int c = 0; c < stim_cycles_lp; c++) begin
      @(posedge clk_i);
      drive_random();
    end
    @(posedge clk_i);
    v_i       <= 1'b0;
    print_v_i <= 1'b0;
    dma_v_i   <= 1'b0;
    @(posedge clk_i);
    while (m_busy) @(posedge clk_i);   // let the last report drain
    repeat (2) @(posedge clk_i);
    if (reports_done == reports_started && reports_done > 5 && strobes_ignored > 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("report count wrong: %0d started, %0d done, %0d strobes ignored",
               reports_started, reports_done, strobes_ignored);
      $display("STATUS: FAIL");
      $fatal(1, "report count check");
    end
  end

endmodule

`default_nettype wire

//--- vcache_profiler_top.sv
// vcache bank profiler top
`timescale 1ns/10ps
`default_nettype none

`include "vcache_prof_defines.svh"

module vcache_profiler_top (
  input  wire logic                                   clk_i,
  input  wire logic                                   reset_i,

  // cache output stage
  input  wire logic                                   v_i,
  input  wire logic                                   yumi_i,
  input  wire logic                                   miss_i,
  input  wire vcache_prof_pkg::cache_decode_s         decode_i,
  input  wire logic [`PROF_MASK_WIDTH-1:0]            mask_i,

  // dma packet port, write_not_read only
  input  wire logic                                   dma_v_i,
  input  wire logic                                   dma_yumi_i,
  input  wire logic                                   dma_write_i,

  input  wire logic [`PROF_CTR_WIDTH-1:0]             global_ctr_i,
  input  wire logic                                   print_v_i,
  input  wire logic [`PROF_TAG_WIDTH-1:0]             print_tag_i,

  output logic                                        rpt_v_o,
  output logic [$clog2(`PROF_RPT_WORDS)-1:0]          rpt_idx_o,
  output logic [`PROF_CTR_WIDTH-1:0]                  rpt_data_o,
  output logic                                        busy_o
);

  vcache_prof_pkg::op_stat_s  op_stat;
  vcache_prof_pkg::act_stat_s act_stat;

  prof_op_counter prof_op_counter_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .v_i       (v_i),
    .yumi_i    (yumi_i),
    .miss_i    (miss_i),
    .decode_i  (decode_i),
    .mask_i    (mask_i),
    .op_stat_o (op_stat)
  );

  prof_activity_counter prof_activity_counter_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .v_i         (v_i),
    .yumi_i      (yumi_i),
    .miss_i      (miss_i),
    .ld_op_i     (decode_i.ld_op),
    .st_op_i     (decode_i.st_op),
    .atomic_op_i (decode_i.atomic_op),
    .dma_v_i     (dma_v_i),
    .dma_yumi_i  (dma_yumi_i),
    .dma_write_i (dma_write_i),
    .act_stat_o  (act_stat)
  );

  prof_report_serializer prof_report_serializer_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .print_v_i    (print_v_i),
    .print_tag_i  (print_tag_i),
    .global_ctr_i (global_ctr_i),
    .op_stat_i    (op_stat),
    .act_stat_i   (act_stat),
    .busy_o       (busy_o),
    .rpt_v_o      (rpt_v_o),
    .rpt_idx_o    (rpt_idx_o),
    .rpt_data_o   (rpt_data_o)
  );

endmodule

`default_nettype wire

//--- prof_report_serializer.sv
// statistics report serializer
`timescale 1ns/10ps
`default_nettype none

`include "vcache_prof_defines.svh"

module prof_report_serializer (
  input  wire logic                                   clk_i,
  input  wire logic                                   reset_i,
  input  wire logic                                   print_v_i,
  input  wire logic [`PROF_TAG_WIDTH-1:0]             print_tag_i,
  input  wire logic [`PROF_CTR_WIDTH-1:0]             global_ctr_i,
  input  wire vcache_prof_pkg::op_stat_s              op_stat_i,
  input  wire vcache_prof_pkg::act_stat_s             act_stat_i,
  output logic                                        busy_o,
  output logic                                        rpt_v_o,
  output logic [$clog2(`PROF_RPT_WORDS)-1:0]          rpt_idx_o,
  output logic [`PROF_CTR_WIDTH-1:0]                  rpt_data_o
);

  localparam int idx_w_lp = $clog2(`PROF_RPT_WORDS);
  localparam logic [idx_w_lp-1:0] last_idx_lp = idx_w_lp'(`PROF_RPT_WORDS - 1);

  logic                                       busy_r;
  logic                                       start;
  logic [idx_w_lp-1:0]                        idx_r;
  // ascending range so word 0 is the leftmost slice of the concatenation
  logic [0:`PROF_RPT_WORDS-1][`PROF_CTR_WIDTH-1:0] snap_r;

  assign start = print_v_i & ~busy_r;   // strobes during a report are dropped

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      idx_r  <= '0;
    end else if (start) begin
      busy_r <= 1'b1;
      idx_r  <= '0;
    end else if (busy_r) begin
      if (idx_r == last_idx_lp) begin
        busy_r <= 1'b0;
        idx_r  <= '0;
      end else begin
        idx_r <= idx_r + 1'b1;
      end
    end
  end

  // counters already hold all events up to the edge before the strobe
  always_ff @(posedge clk_i) begin
    if (start) begin
      snap_r <= {global_ctr_i, print_tag_i, op_stat_i, act_stat_i};
    end
  end

  assign busy_o     = busy_r;
  assign rpt_v_o    = busy_r;         // word 0 goes out right after the strobe edge
  assign rpt_idx_o  = idx_r;
  assign rpt_data_o = snap_r[idx_r];

  a_idx_range: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rpt_idx_o <= last_idx_lp
  ) else $error("report index %0d out of range", rpt_idx_o);

  // a report never stalls or skips a word once started
  a_stream: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (rpt_v_o && rpt_idx_o != last_idx_lp)
      |=> (rpt_v_o && rpt_idx_o == $past(rpt_idx_o) + 1'b1)
  ) else $error("report stream broken after index %0d", $past(rpt_idx_o));

endmodule

`default_nettype wire

//--- prof_activity_counter.sv
// miss, stall, idle and dma counters
`timescale 1ns/10ps
`default_nettype none

`include "vcache_prof_defines.svh"

module prof_activity_counter (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  v_i,
  input  wire logic                  yumi_i,
  input  wire logic                  miss_i,
  input  wire logic                  ld_op_i,
  input  wire logic                  st_op_i,
  input  wire logic                  atomic_op_i,
  input  wire logic                  dma_v_i,
  input  wire logic                  dma_yumi_i,
  input  wire logic                  dma_write_i,
  output vcache_prof_pkg::act_stat_s act_stat_o
);

  logic                        accept;
  logic                        inc_stall;
  logic                        inc_idle;
  logic                        dma_hs;
  logic [`PROF_ACT_FIELDS-1:0] inc;

  assign accept    = v_i & yumi_i;
  assign inc_stall = v_i & ~yumi_i;                 // response blocked downstream
  assign inc_idle  = ~accept & ~miss_i & ~inc_stall;
  assign dma_hs    = dma_v_i & dma_yumi_i;

  // act_stat_s order, msb first
  assign inc = {
    accept & ld_op_i & miss_i,
    accept & st_op_i & miss_i,
    accept & atomic_op_i & miss_i,
    miss_i,
    inc_idle,
    inc_stall,
    dma_hs & ~dma_write_i,
    dma_hs & dma_write_i
  };

  prof_counter_bank #(
    .stat_t (vcache_prof_pkg::act_stat_s),
    .num_p  (`PROF_ACT_FIELDS)
  ) act_bank_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (inc),
    .stat_o  (act_stat_o)
  );

endmodule

`default_nettype wire

//--- prof_op_counter.sv
// operation class counters
`timescale 1ns/10ps
`default_nettype none

`include "vcache_prof_defines.svh"

module prof_op_counter (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  input  wire logic                        v_i,
  input  wire logic                        yumi_i,
  input  wire logic                        miss_i,
  input  wire vcache_prof_pkg::cache_decode_s decode_i,
  input  wire logic [`PROF_MASK_WIDTH-1:0] mask_i,
  output vcache_prof_pkg::op_stat_s        op_stat_o
);

  logic                       accept;
  logic                       inc_ld;
  logic                       inc_st;
  logic                       ld_plain;
  logic                       st_masked;
  logic [1:0]                 ld_size;
  int                         mask_ones;
  logic [`PROF_OP_FIELDS-1:0] inc;

  assign accept    = v_i & yumi_i;
  assign inc_ld    = accept & decode_i.ld_op & ~miss_i;   // hits only
  assign inc_st    = accept & decode_i.st_op & ~miss_i;
  assign ld_plain  = inc_ld & ~decode_i.mask_op;
  assign st_masked = inc_st & decode_i.mask_op;
  assign ld_size   = decode_i.data_size_op;
  assign mask_ones = $countones(mask_i);

  // same order as op_stat_s, first field at the msb
  assign inc = {
    inc_ld,
    ld_plain & (ld_size == 2'd3) &  decode_i.sigext_op,   // ld
    ld_plain & (ld_size == 2'd3) & ~decode_i.sigext_op,   // ldu
    ld_plain & (ld_size == 2'd2) &  decode_i.sigext_op,   // lw
    ld_plain & (ld_size == 2'd2) & ~decode_i.sigext_op,   // lwu
    ld_plain & (ld_size == 2'd1) &  decode_i.sigext_op,   // lh
    ld_plain & (ld_size == 2'd1) & ~decode_i.sigext_op,   // lhu
    ld_plain & (ld_size == 2'd0) &  decode_i.sigext_op,   // lb
    ld_plain & (ld_size == 2'd0) & ~decode_i.sigext_op,   // lbu
    inc_st,
    st_masked & (mask_ones == 8),
    st_masked & (mask_ones == 4),
    st_masked & (mask_ones == 2),
    st_masked & (mask_ones == 1),
    accept & decode_i.tagst_op,     // tag and address ops ignore miss
    accept & decode_i.tagfl_op,
    accept & decode_i.taglv_op,
    accept & decode_i.tagla_op,
    accept & decode_i.afl_op,
    accept & decode_i.aflinv_op,
    accept & decode_i.ainv_op,
    accept & decode_i.alock_op,
    accept & decode_i.aunlock_op,
    accept & decode_i.atomic_op,
    accept & decode_i.atomic_op & (decode_i.amo_subop == vcache_prof_pkg::e_amo_swap),
    accept & decode_i.atomic_op & (decode_i.amo_subop == vcache_prof_pkg::e_amo_or)
  };

  prof_counter_bank #(
    .stat_t (vcache_prof_pkg::op_stat_s),
    .num_p  (`PROF_OP_FIELDS)
  ) op_bank_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (inc),
    .stat_o  (op_stat_o)
  );

  // the cache decodes one operation at a time
  a_one_op: assert property (
    @(posedge clk_i) disable iff (reset_i)
    v_i |-> $onehot0({decode_i.ld_op, decode_i.st_op, decode_i.tagst_op,
                      decode_i.tagfl_op, decode_i.taglv_op, decode_i.tagla_op,
                      decode_i.afl_op, decode_i.aflinv_op, decode_i.ainv_op,
                      decode_i.alock_op, decode_i.aunlock_op, decode_i.atomic_op})
  ) else $error("more than one op bit set with v_i high");

endmodule

`default_nettype wire

//--- prof_counter_bank.sv
// wrapping counter bank
`timescale 1ns/10ps
`default_nettype none

`include "vcache_prof_defines.svh"

module prof_counter_bank #(
  parameter type stat_t = logic [`PROF_CTR_WIDTH-1:0],
  parameter int  num_p  = 1
) (
  input  wire logic             clk_i,
  input  wire logic             reset_i,
  input  wire logic [num_p-1:0] inc_i,   // msb drives first struct field
  output stat_t                 stat_o
);

  logic [num_p-1:0][`PROF_CTR_WIDTH-1:0] ctr_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctr_r <= '0;
    end else begin
      for (int i = 0; i < num_p; i++) begin
        if (inc_i[i]) begin
          ctr_r[i] <= ctr_r[i] + 1'b1;  // wraps, no saturation
        end
      end
    end
  end

  assign stat_o = stat_t'(ctr_r);

  // struct layout must line up one to one with the counters
  a_stat_width: assert property (
    @(posedge clk_i) $bits(stat_t) == num_p * `PROF_CTR_WIDTH
  ) else $error("stat_t is %0d bits, expected %0d counters", $bits(stat_t), num_p);

endmodule

`default_nettype wire

//--- vcache_prof_pkg.sv
// vcache profiler types
`default_nettype none

`include "vcache_prof_defines.svh"

package vcache_prof_pkg;

  typedef enum logic [1:0] {
    e_amo_swap  = 2'd0,
    e_amo_or    = 2'd1,
    e_amo_add   = 2'd2,
    e_amo_other = 2'd3
  } amo_subop_e;

  // decoded operation from the cache output stage
  typedef struct packed {
    logic       ld_op;
    logic       st_op;
    logic       mask_op;        // store uses byte mask
    logic [1:0] data_size_op;   // 3 d, 2 w, 1 h, 0 b
    logic       sigext_op;      // signed load
    logic       tagst_op;
    logic       tagfl_op;
    logic       taglv_op;
    logic       tagla_op;
    logic       afl_op;
    logic       aflinv_op;
    logic       ainv_op;
    logic       alock_op;
    logic       aunlock_op;
    logic       atomic_op;
    amo_subop_e amo_subop;
  } cache_decode_s;

  // first field sits in the top bits, report order follows declaration order
  typedef struct packed {
    logic [`PROF_CTR_WIDTH-1:0] ld;
    logic [`PROF_CTR_WIDTH-1:0] ld_ld;
    logic [`PROF_CTR_WIDTH-1:0] ld_ldu;
    logic [`PROF_CTR_WIDTH-1:0] ld_lw;
    logic [`PROF_CTR_WIDTH-1:0] ld_lwu;
    logic [`PROF_CTR_WIDTH-1:0] ld_lh;
    logic [`PROF_CTR_WIDTH-1:0] ld_lhu;
    logic [`PROF_CTR_WIDTH-1:0] ld_lb;
    logic [`PROF_CTR_WIDTH-1:0] ld_lbu;
    logic [`PROF_CTR_WIDTH-1:0] st;
    logic [`PROF_CTR_WIDTH-1:0] sm_sd;
    logic [`PROF_CTR_WIDTH-1:0] sm_sw;
    logic [`PROF_CTR_WIDTH-1:0] sm_sh;
    logic [`PROF_CTR_WIDTH-1:0] sm_sb;
    logic [`PROF_CTR_WIDTH-1:0] tagst;
    logic [`PROF_CTR_WIDTH-1:0] tagfl;
    logic [`PROF_CTR_WIDTH-1:0] taglv;
    logic [`PROF_CTR_WIDTH-1:0] tagla;
    logic [`PROF_CTR_WIDTH-1:0] afl;
    logic [`PROF_CTR_WIDTH-1:0] aflinv;
    logic [`PROF_CTR_WIDTH-1:0] ainv;
    logic [`PROF_CTR_WIDTH-1:0] alock;
    logic [`PROF_CTR_WIDTH-1:0] aunlock;
    logic [`PROF_CTR_WIDTH-1:0] atomic;
    logic [`PROF_CTR_WIDTH-1:0] amoswap;
    logic [`PROF_CTR_WIDTH-1:0] amoor;
  } op_stat_s;

  typedef struct packed {
    logic [`PROF_CTR_WIDTH-1:0] miss_ld;
    logic [`PROF_CTR_WIDTH-1:0] miss_st;
    logic [`PROF_CTR_WIDTH-1:0] miss_amo;
    logic [`PROF_CTR_WIDTH-1:0] miss_cycles;       // miss handler busy
    logic [`PROF_CTR_WIDTH-1:0] idle_cycles;
    logic [`PROF_CTR_WIDTH-1:0] stall_rsp_cycles;  // response held off
    logic [`PROF_CTR_WIDTH-1:0] dma_read;
    logic [`PROF_CTR_WIDTH-1:0] dma_write;
  } act_stat_s;

endpackage

`default_nettype wire

//--- vcache_prof_defines.svh
// vcache profiler constants
`ifndef VCACHE_PROF_DEFINES_SVH
`define VCACHE_PROF_DEFINES_SVH

`define PROF_CTR_WIDTH 32   // counter and report word width
`define PROF_MASK_WIDTH 8   // store byte mask
`define PROF_TAG_WIDTH 32   // print tag

`define PROF_OP_FIELDS 26   // operation counters
`define PROF_ACT_FIELDS 8   // activity counters

// 2 header words followed by every counter
`define PROF_RPT_WORDS 36

`endif
